//--- flowClassify.sv
// Ingress stage with one cycle of latency; no-op requests are accepted and silently dropped.
`timescale 1ns/100ps

module flowClassify import flowPkg::*; (
  input  logic                 clk,
  input  logic                 rstN,

  input  logic                 pushValid,
  output logic                 pushReady,
  input  logic [DataWidth-1:0] pushData,

  flowStageIf.src              out
);

  // Stage occupancy.
  typedef enum logic {
    stEmpty,
    stFull
  } stateT;

  stateT  state;
  opcodeT pushOp;
  logic   pushXfer;
  logic   popXfer;
  logic   loadItem;

  // ----------------------------------------
  // Decode and handshake
  // ----------------------------------------
  // Opcode sits in the top bits.
  assign pushOp = opcodeT'(pushData[DataWidth-1:OpLsb]);

  // Accept when empty or when the held item moves on.
  assign pushReady = (state == stEmpty) || out.ready;
  assign pushXfer  = pushValid && pushReady;
  assign popXfer   = out.valid && out.ready;

  // Drop ops complete the handshake but are never stored.
  assign loadItem  = pushXfer && !isDropOp(pushOp);

  assign out.valid = (state == stFull);

  // ----------------------------------------
  // Occupancy FSM
  // ----------------------------------------
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= stEmpty;
    end else if (loadItem) begin
      state <= stFull;
    end else if (popXfer) begin
      state <= stEmpty;
    end
  end

  // ----------------------------------------
  // Payload and select registers
  // ----------------------------------------
  // Select is computed on the way in, so it is stable with data.
  always_ff @(posedge clk) begin
    if (loadItem) begin
      out.data   <= pushData;
      out.select <= flowForOp(pushOp);
    end
  end

endmodule

//--- flowDemuxSelect.sv
// Demux with a registered output per flow; in.ready follows the selected flow combinationally.
`timescale 1ns/100ps

module flowDemuxSelect import flowPkg::*; (
  input  logic                                clk,
  input  logic                                rstN,

  flowStageIf.dst                             in,

  output logic [NumFlows-1:0]                 popValid,
  input  logic [NumFlows-1:0]                 popReady,
  output logic [NumFlows-1:0][DataWidth-1:0]  popData
);

  // ----------------------------------------
  // Combinational demux
  // ----------------------------------------
  // Per-flow push side of the output registers.
  logic [NumFlows-1:0]                internalValid;
  logic [NumFlows-1:0]                internalReady;
  logic [NumFlows-1:0][DataWidth-1:0] internalData;

  // Only the selected flow sees its ready.
  // A stalled target blocks the link for every flow.
  assign in.ready = internalReady[in.select];

  // ----------------------------------------
  // Per-flow output registers
  // ----------------------------------------
  for (genvar i = 0; i < NumFlows; i++) begin : genPopReg

    // One-hot valid from the binary select.
    assign internalValid[i] = in.valid && (in.select == SelWidth'(i));

    // Data fans out to every flow.
    // Only the selected register loads it.
    assign internalData[i] = in.data;

    // Registers hide the demux outputs from the pop side.
    // Ready still passes straight through to in.ready.
    flowRegFwd popReg_i (
      .clk       (clk),
      .rstN      (rstN),
      .pushValid (internalValid[i]),
      .pushReady (internalReady[i]),
      .pushData  (internalData[i]),
      .popValid  (popValid[i]),
      .popReady  (popReady[i]),
      .popData   (popData[i])
    );
  end

endmodule

//--- flowPkg.sv
// Shared widths and opcode map; the map assumes exactly four flows and a 3-bit opcode field.
package flowPkg;

  // ----------------------------------------
  // Widths and counts
  // ----------------------------------------
  // Number of output flows.
  localparam int NumFlows = 4;
  // Request width, opcode included.
  localparam int DataWidth = 16;
  // Opcode field, held in the top bits.
  localparam int OpWidth = 3;
  // Lowest bit of the opcode field.
  localparam int OpLsb = DataWidth - OpWidth;
  // Binary flow select.
  localparam int SelWidth = 2;

  // Request opcodes.
  typedef enum logic [OpWidth-1:0] {
    opNop        = 3'd0,
    opRead       = 3'd1,
    opReadBurst  = 3'd2,
    opWrite      = 3'd3,
    opWriteBurst = 3'd4,
    opCtrl       = 3'd5,
    opFence      = 3'd6,
    opDebug      = 3'd7
  } opcodeT;

  // Flow number for an opcode.
  // A no-op has no flow; 0 is returned and never used.
  function automatic logic [SelWidth-1:0] flowForOp(opcodeT op);
    case (op)
      opRead, opReadBurst:   return 2'd0;
      opWrite, opWriteBurst: return 2'd1;
      opCtrl, opFence:       return 2'd2;
      opDebug:               return 2'd3;
      default:               return 2'd0;
    endcase
  endfunction

  // True for requests that are consumed without output.
  function automatic logic isDropOp(opcodeT op);
    return op == opNop;
  endfunction

endpackage

//--- flowRegFwd.sv
// One-entry forward register; pushReady depends combinationally on popReady.
`timescale 1ns/100ps

module flowRegFwd import flowPkg::*; (
  input  logic                 clk,
  input  logic                 rstN,

  input  logic                 pushValid,
  output logic                 pushReady,
  input  logic [DataWidth-1:0] pushData,

  output logic                 popValid,
  input  logic                 popReady,
  output logic [DataWidth-1:0] popData
);

  // ----------------------------------------
  // Handshake
  // ----------------------------------------
  logic pushXfer;

  // Space when empty or when the held item leaves now.
  // This keeps full throughput with a single entry.
  assign pushReady = !popValid || popReady;
  assign pushXfer  = pushValid && pushReady;

  // ----------------------------------------
  // Valid flag
  // ----------------------------------------
  // A push sets the flag, even in the cycle of a pop.
  // A pop alone clears it.
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      popValid <= 1'b0;
    end else if (pushXfer) begin
      popValid <= 1'b1;
    end else if (popReady) begin
      popValid <= 1'b0;
    end
  end

  // ----------------------------------------
  // Data register
  // ----------------------------------------
  // Loaded only on a push transfer.
  // Upstream glitches on pushData never reach popData.
  always_ff @(posedge clk) begin
    if (pushXfer) begin
      popData <= pushData;
    end
  end

endmodule

//--- flowStageIf.sv
// Ready-valid link with a flow select; valid, data and select must hold while ready is low.
`timescale 1ns/100ps

interface flowStageIf import flowPkg::*; ();

  // ----------------------------------------
  // Link signals
  // ----------------------------------------
  // Item present on the link.
  logic                 valid;
  // Consumer can take the item.
  logic                 ready;
  // Request word, opcode in the top bits.
  logic [DataWidth-1:0] data;
  // Target output flow.
  logic [SelWidth-1:0]  select;

  // Producer side.
  modport src (
    output valid,
    output data,
    output select,
    input  ready
  );

  // Consumer side.
  modport dst (
    input  valid,
    input  data,
    input  select,
    output ready
  );

endinterface

//--- flowSteerTb.sv
// Reads flowSteerTests.txt from the working directory; latency is only checked while popReady is all high.
`timescale 1ns/100ps

module flowSteerTb import flowPkg::*; ();

  localparam logic [31:0] Seed      = 32'h8a5d_1419;
  localparam int          HistDepth = 8192;

  logic                               clk = 1'b0;
  logic                               rstN;
  logic                               pushValid;
  logic                               pushReady;
  logic [DataWidth-1:0]               pushData;
  logic [NumFlows-1:0]                popValid;
  logic [NumFlows-1:0]                popReady;
  logic [NumFlows-1:0][DataWidth-1:0] popData;

  // Requests and stall flags from the data file.
  logic [DataWidth-1:0] reqData [$];
  logic                 reqStall [$];
  // Per-flow scoreboard, with the edge at which each item was accepted.
  logic [DataWidth-1:0] expData [NumFlows][$];
  int                   expEdge [NumFlows][$];
  // Edges at which every popReady bit was high.
  bit                   cleanAt [HistDepth];

  int cycleCount    = 0;
  int limitCycles   = 0;
  int dataErrors    = 0;
  int routeErrors   = 0;
  int latencyErrors = 0;
  int otherErrors   = 0;
  int expectCount   = 0;
  int popCount      = 0;
  bit resetSeen     = 1'b0;

  flowSteerTop dut_i (
    .clk       (clk),
    .rstN      (rstN),
    .pushValid (pushValid),
    .pushReady (pushReady),
    .pushData  (pushData),
    .popValid  (popValid),
    .popReady  (popReady),
    .popData   (popData)
  );

  // 10 ns clock.
  always #5 clk = ~clk;

  // ----------------------------------------
  // Reference rules
  // ----------------------------------------
  // Reads and writes share a flow per kind, ctrl and fence share flow 2.
  function automatic int flowOfOpcode(opcodeT op);
    case (op)
      opRead, opReadBurst:   return 0;
      opWrite, opWriteBurst: return 1;
      opCtrl, opFence:       return 2;
      default:               return 3;
    endcase
  endfunction

  // Each bit low about 30 percent of the time.
  function automatic logic [NumFlows-1:0] randomReady();
    logic [NumFlows-1:0] r;
    for (int i = 0; i < NumFlows; i++) begin
      r[i] = ($urandom % 100) >= 30;
    end
    return r;
  endfunction

  function automatic int pendingItems();
    int n;
    n = 0;
    for (int i = 0; i < NumFlows; i++) begin
      n += expData[i].size();
    end
    return n;
  endfunction

  // ----------------------------------------
  // Scoreboard
  // ----------------------------------------
  task automatic recordAccept();
    logic [OpWidth-1:0] op;
    int                 flow;
    op = pushData[DataWidth-1:OpLsb];
    // No-ops are consumed by the classifier.
    if (op != opNop) begin
      flow = flowOfOpcode(opcodeT'(op));
      expData[flow].push_back(pushData);
      expEdge[flow].push_back(cycleCount);
      expectCount++;
    end
  endtask

  task automatic checkPop(input int flow);
    logic [DataWidth-1:0] expVal;
    logic [OpWidth-1:0]   op;
    int                   acceptAt;
    op = popData[flow][DataWidth-1:OpLsb];
    popCount++;
    if (op == opNop) begin
      $display("A dropped no-op request appeared on flow %0d at %0t.", flow, $time);
      otherErrors++;
    end else if (flowOfOpcode(opcodeT'(op)) != flow) begin
      $display("ERROR t=%0t popData[%0d] flow expected %0d actual %0d",
               $time, flow, flowOfOpcode(opcodeT'(op)), flow);
      routeErrors++;
    end
    if (expData[flow].size() == 0) begin
      $display("Flow %0d popped an item at %0t with nothing expected.", flow, $time);
      routeErrors++;
    end else begin
      expVal   = expData[flow].pop_front();
      acceptAt = expEdge[flow].pop_front();
      if (popData[flow] !== expVal) begin
        $display("ERROR t=%0t popData[%0d] expected %h actual %h",
                 $time, flow, expVal, popData[flow]);
        dataErrors++;
      end
      // Two edges when nothing pushed back in between.
      if (acceptAt + 2 < HistDepth && cleanAt[acceptAt + 1] && cleanAt[acceptAt + 2]
          && cycleCount != acceptAt + 2) begin
        $display("ERROR t=%0t popValid[%0d] latency expected 2 actual %0d",
                 $time, flow, cycleCount - acceptAt);
        latencyErrors++;
      end
    end
  endtask

  // ----------------------------------------
  // Edge monitor and timeout
  // ----------------------------------------
  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount < HistDepth) begin
      cleanAt[cycleCount] = (popReady == '1);
    end
    if (cycleCount >= limitCycles) begin
      $display("The run timed out after %0d cycles with requests still pending.", cycleCount);
      $display("TEST FAILED");
      $finish;
    end else if (rstN) begin
      // First edge after release.
      if (!resetSeen && popValid != '0) begin
        $display("ERROR t=%0t popValid expected %h actual %h", $time, 4'h0, popValid);
        otherErrors++;
      end
      resetSeen = 1'b1;
      for (int i = 0; i < NumFlows; i++) begin
        if (popValid[i] && popReady[i]) begin
          checkPop(i);
        end
      end
      if (pushValid && pushReady) begin
        recordAccept();
      end
    end
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin
    int          fd;
    int          n;
    string       lineStr;
    logic [31:0] opVal;
    logic [31:0] payVal;
    logic [31:0] stallVal;
    rstN      = 1'b0;
    pushValid = 1'b0;
    pushData  = '0;
    popReady  = '1;
    void'($urandom(Seed));
    fd = $fopen("flowSteerTests.txt", "r");
    if (fd == 0) begin
      $display("Could not open flowSteerTests.txt.");
      otherErrors++;
    end else begin
      // Comment lines fail the scan and are skipped.
      while (!$feof(fd)) begin
        n = $fgets(lineStr, fd);
        if (n > 0 && $sscanf(lineStr, "%h %h %h", opVal, payVal, stallVal) == 3) begin
          reqData.push_back({opVal[OpWidth-1:0], payVal[OpLsb-1:0]});
          reqStall.push_back(stallVal[0]);
        end
      end
      $fclose(fd);
    end
    limitCycles = 40 * reqData.size() + 200;
    repeat (10) @(negedge clk);
    rstN = 1'b1;
    // Hold each request until a rising edge sees pushReady.
    for (int k = 0; k < reqData.size(); k++) begin
      do begin
        @(negedge clk);
        pushValid = 1'b1;
        pushData  = reqData[k];
        popReady  = reqStall[k] ? randomReady() : '1;
        @(posedge clk);
      end while (!pushReady);
    end
    @(negedge clk);
    pushValid = 1'b0;
    popReady  = '1;
    while (pendingItems() != 0) begin
      @(negedge clk);
    end
    // A few idle edges to catch stray pops.
    repeat (5) @(negedge clk);
    if (popCount != expectCount) begin
      $display("Popped %0d items but %0d were expected.", popCount, expectCount);
      otherErrors++;
    end
    $display("Errors: data %0d, routing %0d, latency %0d, other %0d",
             dataErrors, routeErrors, latencyErrors, otherErrors);
    if (dataErrors + routeErrors + latencyErrors + otherErrors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- flowSteerTests.txt
// Columns, all hex: opcode (0-7), 13-bit payload, stall flag (1 = random popReady).
// Opcodes: 0 nop, 1 read, 2 read burst, 3 write, 4 write burst, 5 ctrl, 6 fence, 7 debug.
1 0001 0
3 0102 0
5 0203 0
7 0304 0
0 0405 0
2 0506 0
4 0607 0
6 0708 0
1 0809 0
1 090a 0
0 0a0b 1
7 0b0c 1
7 0c0d 1
3 0d0e 1
2 0e0f 1
5 0f10 1
4 1011 1
6 1112 1
0 1213 0
2 1314 0
3 1415 0
7 1fff 0

//--- flowSteerTop.f
flowPkg.sv
flowStageIf.sv
flowRegFwd.sv
flowClassify.sv
flowDemuxSelect.sv
flowSteerTop.sv
flowSteer_checker.sv
flowSteerTb.sv

//--- flowSteerTop.sv
// Four-flow steering pipeline with two cycles of latency; a stalled flow blocks every other flow.
`timescale 1ns/100ps

module flowSteerTop import flowPkg::*; (
  input  logic                                clk,
  input  logic                                rstN,

  // ----------------------------------------
  // Request side
  // ----------------------------------------
  input  logic                                pushValid,
  output logic                                pushReady,
  input  logic [DataWidth-1:0]                pushData,

  // ----------------------------------------
  // Output flows
  // ----------------------------------------
  output logic [NumFlows-1:0]                 popValid,
  input  logic [NumFlows-1:0]                 popReady,
  output logic [NumFlows-1:0][DataWidth-1:0]  popData
);

  // Link from the classifier to the demux.
  flowStageIf stageBus ();

  // Registers the request and decodes its flow.
  // No-ops end here.
  flowClassify classify_i (
    .clk       (clk),
    .rstN      (rstN),
    .pushValid (pushValid),
    .pushReady (pushReady),
    .pushData  (pushData),
    .out       (stageBus.src)
  );

  // Routes each item to its flow register.
  flowDemuxSelect demux_i (
    .clk      (clk),
    .rstN     (rstN),
    .in       (stageBus.dst),
    .popValid (popValid),
    .popReady (popReady),
    .popData  (popData)
  );

endmodule

//--- flowSteer_checker.sv
// Pop-side handshake checks on flowSteerTop; assumes rstN is released between clock edges.
`timescale 1ns/100ps

module flowSteer_checker import flowPkg::*; (
  input logic                               clk,
  input logic                               rstN,
  input logic                               pushReady,
  input logic [NumFlows-1:0]                popValid,
  input logic [NumFlows-1:0]                popReady,
  input logic [NumFlows-1:0][DataWidth-1:0] popData
);

  // ----------------------------------------
  // Stability under back-pressure
  // ----------------------------------------
  for (genvar i = 0; i < NumFlows; i++) begin : genHold
    holdWhileStalled: assert property (@(posedge clk) disable iff (!rstN)
      popValid[i] && !popReady[i] |=> popValid[i] && $stable(popData[i]))
      else $error("Flow %0d dropped or changed its item while stalled.", i);
  end

  // Stages are empty right after reset.
  quietAfterReset: assert property (@(posedge clk) $rose(rstN) |-> popValid == '0)
    else $error("popValid was set on the first edge after reset.");

  // With nothing held at the outputs, the pipeline must take a request.
  readyWhenIdle: assert property (@(posedge clk) disable iff (!rstN)
    popValid == '0 |-> pushReady)
    else $error("pushReady was low while no flow held an item.");

endmodule

bind flowSteerTop flowSteer_checker chk_i (
  .clk       (clk),
  .rstN      (rstN),
  .pushReady (pushReady),
  .popValid  (popValid),
  .popReady  (popReady),
  .popData   (popData)
);

//--- runSim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the pass line.
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module flowSteerTb -f flowSteerTop.f -o simBin
if [ $? -ne 0 ]; then
  echo "Verilator build failed."
  exit 1
fi

./obj_dir/simBin > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status."
  exit 1
fi

if grep -q "^TEST OK$" "$LOG"; then
  exit 0
fi
echo "Pass line not found in $LOG."
exit 1
